//--- flist.f
+incdir+verilog
+incdir+dv
verilog/riscv_isa_pkg.sv
verilog/core_pipe_pkg.sv
verilog/decode_stage.sv
verilog/scoreboard_fifo.sv
verilog/commit_stage.sv
verilog/mini_core.sv
dv/tb_mini_core.sv

//--- Makefile
TOP := tb_mini_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f flist.f -Mdir obj_dir
	@out="$$(obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

//--- dv/tb_mini_core_tests.svh
    // ------------------------------
    // Instruction encoders
    // ------------------------------
    function automatic instr_t addi_instr(input reg_addr_t rd, input reg_addr_t rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, 3'h0, rd, 7'h13};
    endfunction

    function automatic instr_t lui_instr(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, 7'h37};
    endfunction

    function automatic instr_t add_instr(input reg_addr_t rd, input reg_addr_t rs1,
                                         input reg_addr_t rs2);
        return {7'h00, rs2, rs1, 3'h0, rd, 7'h33};
    endfunction

    function automatic instr_t sub_instr(input reg_addr_t rd, input reg_addr_t rs1,
                                         input reg_addr_t rs2);
        return {7'h20, rs2, rs1, 3'h0, rd, 7'h33};
    endfunction

    function automatic instr_t xor_instr(input reg_addr_t rd, input reg_addr_t rs1,
                                         input reg_addr_t rs2);
        return {7'h00, rs2, rs1, 3'h4, rd, 7'h33};
    endfunction

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic check_reset_state();
        int err_before;
        err_before = errors;
        @(negedge clk_i);
        check_value("commit_valid_o", 32'h0, 32'(commit_valid_o));
        check_value("fetch_ready_o", 32'h1, 32'(fetch_ready_o));
        check_value("instret_o", 32'h0, instret_o);
        finish_test("reset state", err_before);
    endtask

    // Each result feeds a later instruction
    task automatic alu_sequence();
        int err_before;
        err_before = errors;
        prog_q.push_back(lui_instr(5'd1, 20'h12345));
        prog_q.push_back(addi_instr(5'd1, 5'd1, 12'h678));
        prog_q.push_back(addi_instr(5'd2, 5'd0, 12'hfff));
        prog_q.push_back(add_instr(5'd3, 5'd1, 5'd2));
        prog_q.push_back(sub_instr(5'd4, 5'd3, 5'd1));
        prog_q.push_back(xor_instr(5'd5, 5'd4, 5'd1));
        prog_q.push_back(lui_instr(5'd6, 20'h80000));
        prog_q.push_back(addi_instr(5'd6, 5'd6, 12'h800));
        prog_q.push_back(sub_instr(5'd7, 5'd0, 5'd6));
        prog_q.push_back(xor_instr(5'd8, 5'd7, 5'd5));
        run_program(1'b0);
        finish_test("alu sequence", err_before);
    endtask

    task automatic x0_writes();
        int err_before;
        err_before = errors;
        prog_q.push_back(addi_instr(5'd0, 5'd1, 12'h123));
        prog_q.push_back(lui_instr(5'd0, 20'hfffff));
        // Reads of x0 after the writes must see zero
        prog_q.push_back(add_instr(5'd9, 5'd0, 5'd0));
        prog_q.push_back(xor_instr(5'd10, 5'd0, 5'd1));
        run_program(1'b0);
        finish_test("x0 writes", err_before);
    endtask

    task automatic illegal_instr();
        int err_before;
        err_before = errors;
        prog_q.push_back(addi_instr(5'd11, 5'd0, 12'h00f));
        prog_q.push_back(32'hffff_ffff);
        // ECALL and OR are outside the decoded subset
        prog_q.push_back(32'h0000_0073);
        prog_q.push_back(32'h00b5_e633);
        prog_q.push_back(add_instr(5'd13, 5'd11, 5'd11));
        run_program(1'b0);
        finish_test("illegal instruction", err_before);
    endtask

    task automatic random_stalls();
        int          err_before;
        logic [31:0] r;
        err_before = errors;
        for (int i = 0; i < N_STALL; i++) begin
            r = $random(seed);
            case (r[2:0])
                3'd2:    prog_q.push_back(lui_instr(r[7:3], r[27:8]));
                3'd3:    prog_q.push_back(add_instr(r[7:3], r[12:8], r[17:13]));
                3'd4:    prog_q.push_back(sub_instr(r[7:3], r[12:8], r[17:13]));
                3'd5:    prog_q.push_back(xor_instr(r[7:3], r[12:8], r[17:13]));
                3'd6:    prog_q.push_back({r[31:7], 7'h7f});
                default: prog_q.push_back(addi_instr(r[7:3], r[12:8], r[24:13]));
            endcase
        end
        run_program(1'b1);
        finish_test("random stalls", err_before);
    endtask

    // Idle core, report due 3 cycles after the accepting edge
    task automatic commit_latency();
        int err_before;
        int cycles;
        err_before = errors;
        @(negedge clk_i);
        commit_ready_i = 1'b1;
        fetch_valid_i  = 1'b1;
        fetch_i.pc     = next_pc;
        fetch_i.instr  = addi_instr(5'd14, 5'd1, 12'h001);
        assert (fetch_ready_o) else begin
            $display("Fetch was not accepted by an idle core");
            errors++;
        end
        model_step(fetch_i);
        next_pc += 32'd4;
        cycles = 0;
        do begin
            @(negedge clk_i);
            fetch_valid_i = 1'b0;
            cycles++;
        end while (!commit_valid_o && cycles < 10);
        assert (cycles == 3) else begin
            $display("Commit report came %0d cycles after acceptance instead of 3", cycles);
            errors++;
        end
        if (commit_valid_o) compare_commit();
        finish_test("commit latency", err_before);
    endtask

//--- dv/tb_mini_core.sv
`timescale 1ns/100ps

`include "core_params.svh"

module tb_mini_core;
    import riscv_isa_pkg::*;
    import core_pipe_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;

    // Instructions sent by each test
    localparam int N_ALU     = 10;
    localparam int N_X0      = 4;
    localparam int N_ILLEGAL = 5;
    localparam int N_STALL   = 40;
    localparam int N_LATENCY = 1;
    localparam int N_TOTAL   = N_ALU + N_X0 + N_ILLEGAL + N_STALL + N_LATENCY;

    logic         clk_i;
    logic         rst_ni;
    fetch_entry_t fetch_i;
    logic         fetch_valid_i;
    logic         fetch_ready_o;
    commit_t      commit_o;
    logic         commit_valid_o;
    logic         commit_ready_i;
    xlen_t        instret_o;

    // Reference model state
    xlen_t   model_regs [`CORE_NR_REGS];
    xlen_t   model_instret;
    xlen_t   next_pc;
    commit_t exp_q [$];
    instr_t  prog_q [$];
    int      seed;
    int      errors;
    int      tests_run;

    mini_core i_mini_core (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .fetch_i        ( fetch_i        ),
        .fetch_valid_i  ( fetch_valid_i  ),
        .fetch_ready_o  ( fetch_ready_o  ),
        .commit_o       ( commit_o       ),
        .commit_valid_o ( commit_valid_o ),
        .commit_ready_i ( commit_ready_i ),
        .instret_o      ( instret_o      )
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Watchdog, 20 cycles per instruction on top of reset
    initial begin
        #((N_TOTAL * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before all tests completed");
        $display("TB FAILED");
        $finish;
    end

    // ------------------------------
    // Checking helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("** Error: %s expected %h, got %h", name, exp_val, act_val);
            errors++;
        end
    endtask

    // RV32I semantics for the supported subset, everything else traps
    task automatic model_step(input fetch_entry_t f);
        commit_t    exp;
        logic [2:0] f3;
        logic [6:0] f7;
        xlen_t      a;
        xlen_t      b;
        logic       legal;
        f3        = f.instr[14:12];
        f7        = f.instr[31:25];
        a         = model_regs[f.instr[19:15]];
        b         = model_regs[f.instr[24:20]];
        legal     = 1'b1;
        exp       = '0;
        exp.pc    = f.pc;
        exp.rd    = f.instr[11:7];
        case (f.instr[6:0])
            7'h13: begin
                legal     = (f3 == 3'h0);
                exp.wdata = a + {{20{f.instr[31]}}, f.instr[31:20]};
            end
            7'h37: exp.wdata = {f.instr[31:12], 12'h000};
            7'h33: begin
                if (f3 == 3'h0 && f7 == 7'h00) exp.wdata = a + b;
                else if (f3 == 3'h0 && f7 == 7'h20) exp.wdata = a - b;
                else if (f3 == 3'h4 && f7 == 7'h00) exp.wdata = a ^ b;
                else legal = 1'b0;
            end
            default: legal = 1'b0;
        endcase
        exp.we = legal && (exp.rd != '0);
        if (!legal) begin
            exp.exc.valid = 1'b1;
            exp.exc.cause = 4'd2;
            exp.exc.tval  = f.instr;
        end else begin
            model_instret++;
        end
        if (exp.we) model_regs[exp.rd] = exp.wdata;
        exp_q.push_back(exp);
    endtask

    task automatic compare_commit();
        commit_t exp;
        logic    pending;
        pending = (exp_q.size() > 0);
        assert (pending) else begin
            $display("Commit report seen with no instruction outstanding");
            errors++;
        end
        if (pending) begin
            exp = exp_q.pop_front();
            check_value("commit_o.pc", exp.pc, commit_o.pc);
            check_value("commit_o.we", 32'(exp.we), 32'(commit_o.we));
            check_value("commit_o.exc.valid", 32'(exp.exc.valid), 32'(commit_o.exc.valid));
            if (exp.exc.valid) begin
                check_value("commit_o.exc.cause", 32'(exp.exc.cause), 32'(commit_o.exc.cause));
                check_value("commit_o.exc.tval", exp.exc.tval, commit_o.exc.tval);
            end else begin
                check_value("commit_o.rd", 32'(exp.rd), 32'(commit_o.rd));
                if (exp.we) check_value("commit_o.wdata", exp.wdata, commit_o.wdata);
            end
        end
    endtask

    // Sends prog_q and checks every report, optionally with random stalls
    task automatic run_program(input logic stall);
        int   sent;
        int   done;
        logic taken;
        sent  = 0;
        done  = 0;
        taken = 1'b0;
        while (done < prog_q.size()) begin
            @(negedge clk_i);
            // A refused fetch stays on the bus unchanged
            if (!fetch_valid_i || taken) begin
                fetch_valid_i = (sent < prog_q.size()) && (!stall || $random(seed) % 3 != 0);
                fetch_i.pc    = next_pc;
                fetch_i.instr = (sent < prog_q.size()) ? prog_q[sent] : '0;
            end
            commit_ready_i = !stall || ($random(seed) % 2 == 0);
            // Transfers at the coming rising edge
            taken = fetch_valid_i && fetch_ready_o;
            if (taken) begin
                model_step(fetch_i);
                next_pc += 32'd4;
                sent++;
            end
            if (commit_valid_o && commit_ready_i) begin
                compare_commit();
                done++;
            end
        end
        prog_q.delete();
    endtask

    task automatic finish_test(input string name, input int err_before);
        @(negedge clk_i);
        check_value("instret_o", model_instret, instret_o);
        tests_run++;
        $display("%s: finished with %0d errors", name, errors - err_before);
    endtask

    `include "tb_mini_core_tests.svh"

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        seed           = 32'h159c;
        errors         = 0;
        tests_run      = 0;
        model_instret  = '0;
        next_pc        = 32'h0000_1000;
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        fetch_i        = '0;
        fetch_valid_i  = 1'b0;
        commit_ready_i = 1'b0;
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;

        check_reset_state();
        alu_sequence();
        x0_writes();
        illegal_instr();
        random_stalls();
        commit_latency();

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/mini_core.sv
`timescale 1ns/100ps

module mini_core (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  core_pipe_pkg::fetch_entry_t fetch_i,
    input  logic                        fetch_valid_i,
    output logic                        fetch_ready_o,
    output core_pipe_pkg::commit_t      commit_o,
    output logic                        commit_valid_o,
    input  logic                        commit_ready_i,
    output riscv_isa_pkg::xlen_t        instret_o
);
    import core_pipe_pkg::*;

    // Decode to scoreboard
    sb_entry_t sb_entry_dec_sb;
    logic      sb_valid_dec_sb;
    logic      sb_ready_sb_dec;

    // Scoreboard to commit
    sb_entry_t sb_entry_sb_cmt;
    logic      sb_valid_sb_cmt;
    logic      sb_ready_cmt_sb;

    // ------------------------------
    // Decode
    // ------------------------------
    decode_stage i_decode_stage (
        .clk_i         ( clk_i           ),
        .rst_ni        ( rst_ni          ),
        .fetch_i       ( fetch_i         ),
        .fetch_valid_i ( fetch_valid_i   ),
        .fetch_ready_o ( fetch_ready_o   ),
        .sb_entry_o    ( sb_entry_dec_sb ),
        .sb_valid_o    ( sb_valid_dec_sb ),
        .sb_ready_i    ( sb_ready_sb_dec )
    );

    // ------------------------------
    // Scoreboard
    // ------------------------------
    scoreboard_fifo i_scoreboard_fifo (
        .clk_i        ( clk_i           ),
        .rst_ni       ( rst_ni          ),
        .push_entry_i ( sb_entry_dec_sb ),
        .push_valid_i ( sb_valid_dec_sb ),
        .push_ready_o ( sb_ready_sb_dec ),
        .pop_entry_o  ( sb_entry_sb_cmt ),
        .pop_valid_o  ( sb_valid_sb_cmt ),
        .pop_ready_i  ( sb_ready_cmt_sb )
    );

    // ------------------------------
    // Commit
    // ------------------------------
    commit_stage i_commit_stage (
        .clk_i          ( clk_i           ),
        .rst_ni         ( rst_ni          ),
        .sb_entry_i     ( sb_entry_sb_cmt ),
        .sb_valid_i     ( sb_valid_sb_cmt ),
        .sb_ready_o     ( sb_ready_cmt_sb ),
        .commit_o       ( commit_o        ),
        .commit_valid_o ( commit_valid_o  ),
        .commit_ready_i ( commit_ready_i  ),
        .instret_o      ( instret_o       )
    );

endmodule

//--- verilog/commit_stage.sv
`timescale 1ns/100ps

`include "core_params.svh"

module commit_stage (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  core_pipe_pkg::sb_entry_t sb_entry_i,
    input  logic                     sb_valid_i,
    output logic                     sb_ready_o,
    output core_pipe_pkg::commit_t   commit_o,
    output logic                     commit_valid_o,
    input  logic                     commit_ready_i,
    output riscv_isa_pkg::xlen_t     instret_o
);
    import riscv_isa_pkg::*;
    import core_pipe_pkg::*;

    localparam int unsigned NR_REGS = `CORE_NR_REGS;

    xlen_t   regs_q [NR_REGS];
    xlen_t   rs1_data;
    xlen_t   rs2_data;
    xlen_t   op_b;
    xlen_t   alu_result;
    logic    pop;
    logic    reg_we;
    commit_t commit_q;
    logic    commit_valid_q;
    xlen_t   instret_q;

    assign sb_ready_o = !commit_valid_q || commit_ready_i;
    assign pop        = sb_valid_i && sb_ready_o;

    // ------------------------------
    // Operand read and ALU
    // ------------------------------

    // Commit is in order so the file always holds the latest values
    assign rs1_data = regs_q[sb_entry_i.rs1];
    assign rs2_data = regs_q[sb_entry_i.rs2];
    assign op_b     = sb_entry_i.use_imm ? sb_entry_i.imm : rs2_data;

    always_comb begin
        case (sb_entry_i.op)
            ALU_ADD:      alu_result = rs1_data + op_b;
            ALU_SUB:      alu_result = rs1_data - op_b;
            ALU_XOR:      alu_result = rs1_data ^ op_b;
            ALU_PASS_IMM: alu_result = sb_entry_i.imm;
            default:      alu_result = '0;
        endcase
    end

    // x0 stays hard-wired to zero
    assign reg_we = sb_entry_i.we_rd && !sb_entry_i.exc.valid && (sb_entry_i.rd != '0);

    // ------------------------------
    // Register file
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NR_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (pop && reg_we) begin
            regs_q[sb_entry_i.rd] <= alu_result;
        end
    end

    // ------------------------------
    // Commit report and instret
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            commit_valid_q <= 1'b0;
            instret_q      <= '0;
        end else begin
            if (sb_ready_o) begin
                commit_valid_q <= sb_valid_i;
            end
            // Trapped instructions do not retire
            if (pop && !sb_entry_i.exc.valid) begin
                instret_q <= instret_q + xlen_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            commit_q.pc    <= sb_entry_i.pc;
            commit_q.rd    <= sb_entry_i.rd;
            commit_q.wdata <= alu_result;
            commit_q.we    <= reg_we;
            commit_q.exc   <= sb_entry_i.exc;
        end
    end

    assign commit_o       = commit_q;
    assign commit_valid_o = commit_valid_q;
    assign instret_o      = instret_q;

    a_commit_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_valid_o && !commit_ready_i |=> commit_valid_o && $stable(commit_o));

endmodule

//--- verilog/scoreboard_fifo.sv
`timescale 1ns/100ps

`include "core_params.svh"

module scoreboard_fifo (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  core_pipe_pkg::sb_entry_t push_entry_i,
    input  logic                     push_valid_i,
    output logic                     push_ready_o,
    output core_pipe_pkg::sb_entry_t pop_entry_o,
    output logic                     pop_valid_o,
    input  logic                     pop_ready_i
);
    import core_pipe_pkg::*;

    localparam int unsigned DEPTH = `CORE_SB_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    localparam cnt_t FULL = cnt_t'(DEPTH);

    sb_entry_t mem_q [DEPTH];
    ptr_t      wr_ptr_q;
    ptr_t      rd_ptr_q;
    cnt_t      count_q;
    logic      push;
    logic      pop;

    assign push_ready_o = (count_q != FULL);
    assign pop_valid_o  = (count_q != '0);
    assign pop_entry_o  = mem_q[rd_ptr_q];

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_ready_i && pop_valid_o;

    // ------------------------------
    // Pointers and fill level
    // ------------------------------

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + ptr_t'(1);
            end
            if (push && !pop) begin
                count_q <= count_q + cnt_t'(1);
            end else if (pop && !push) begin
                count_q <= count_q - cnt_t'(1);
            end
        end
    end

    // Storage, head only seen after the write edge
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_entry_i;
        end
    end

    // Refused push is held by the producer, never dropped
    a_full_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_entry_i));

    // Read pointer never overtakes the write pointer
    a_empty_ptrs: assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_q == '0 |-> rd_ptr_q == wr_ptr_q);

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  core_pipe_pkg::fetch_entry_t fetch_i,
    input  logic                        fetch_valid_i,
    output logic                        fetch_ready_o,
    output core_pipe_pkg::sb_entry_t    sb_entry_o,
    output logic                        sb_valid_o,
    input  logic                        sb_ready_i
);
    import riscv_isa_pkg::*;
    import core_pipe_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    logic      legal;
    sb_entry_t decoded;
    sb_entry_t entry_q;
    logic      valid_q;

    assign opcode = fetch_i.instr[6:0];
    assign funct3 = fetch_i.instr[14:12];
    assign funct7 = fetch_i.instr[31:25];

    // ------------------------------
    // Instruction decode
    // ------------------------------
    always_comb begin
        decoded     = '0;
        decoded.pc  = fetch_i.pc;
        decoded.rs1 = fetch_i.instr[19:15];
        decoded.rs2 = fetch_i.instr[24:20];
        decoded.rd  = fetch_i.instr[11:7];
        legal       = 1'b0;

        case (opcode)
            OPC_OP_IMM: begin
                // Only ADDI among the immediate ops
                legal           = (funct3 == F3_ADD_SUB);
                decoded.op      = ALU_ADD;
                decoded.imm     = xlen_t'($signed(fetch_i.instr[31:20]));
                decoded.use_imm = 1'b1;
            end
            OPC_LUI: begin
                legal           = 1'b1;
                decoded.op      = ALU_PASS_IMM;
                decoded.imm     = xlen_t'($signed({fetch_i.instr[31:12], 12'b0}));
                decoded.use_imm = 1'b1;
            end
            OPC_OP: begin
                if (funct3 == F3_ADD_SUB && funct7 == F7_BASE) begin
                    legal      = 1'b1;
                    decoded.op = ALU_ADD;
                end else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) begin
                    legal      = 1'b1;
                    decoded.op = ALU_SUB;
                end else if (funct3 == F3_XOR && funct7 == F7_BASE) begin
                    legal      = 1'b1;
                    decoded.op = ALU_XOR;
                end
            end
            default: legal = 1'b0;
        endcase

        decoded.we_rd = legal;
        if (!legal) begin
            decoded.exc.valid = 1'b1;
            decoded.exc.cause = EXC_ILLEGAL_INSTR;
            decoded.exc.tval  = xlen_t'(fetch_i.instr);
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------

    // Accept when empty or when the FIFO drains us this cycle
    assign fetch_ready_o = !valid_q || sb_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (fetch_ready_o) begin
            valid_q <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_valid_i && fetch_ready_o) begin
            entry_q <= decoded;
        end
    end

    assign sb_entry_o = entry_q;
    assign sb_valid_o = valid_q;

    a_hold_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
        sb_valid_o && !sb_ready_i |=> sb_valid_o && $stable(sb_entry_o));

endmodule

//--- verilog/core_pipe_pkg.sv
package core_pipe_pkg;

    // ALU operation select
    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD      = 3'd0;
    localparam alu_op_t ALU_SUB      = 3'd1;
    localparam alu_op_t ALU_XOR      = 3'd2;
    localparam alu_op_t ALU_PASS_IMM = 3'd3;

    // ------------------------------
    // Pipeline payloads
    // ------------------------------
    typedef struct packed {
        logic                     valid;
        riscv_isa_pkg::exc_cause_t cause;
        riscv_isa_pkg::xlen_t      tval;
    } exc_t;

    typedef struct packed {
        riscv_isa_pkg::xlen_t  pc;
        riscv_isa_pkg::instr_t instr;
    } fetch_entry_t;

    typedef struct packed {
        riscv_isa_pkg::xlen_t     pc;
        alu_op_t                  op;
        riscv_isa_pkg::reg_addr_t rs1;
        riscv_isa_pkg::reg_addr_t rs2;
        riscv_isa_pkg::reg_addr_t rd;
        riscv_isa_pkg::xlen_t     imm;
        logic                     use_imm;
        logic                     we_rd;
        exc_t                     exc;
    } sb_entry_t;

    // Retirement report, one per instruction
    typedef struct packed {
        riscv_isa_pkg::xlen_t     pc;
        riscv_isa_pkg::reg_addr_t rd;
        riscv_isa_pkg::xlen_t     wdata;
        logic                     we;
        exc_t                     exc;
    } commit_t;

endpackage

//--- verilog/riscv_isa_pkg.sv
`include "core_params.svh"

package riscv_isa_pkg;

    // ------------------------------
    // Basic ISA types
    // ------------------------------
    typedef logic [4:0]            reg_addr_t;
    typedef logic [`CORE_XLEN-1:0] xlen_t;
    typedef logic [31:0]           instr_t;
    typedef logic [3:0]            exc_cause_t;

    // Instruction field slices
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // ------------------------------
    // Opcodes
    // ------------------------------
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // funct3, ADDI shares the ADD/SUB code
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_XOR     = 3'b100;

    // funct7 for register-register ops
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_SUB  = 7'b0100000;

    // ------------------------------
    // Exception causes
    // ------------------------------
    localparam exc_cause_t EXC_ILLEGAL_INSTR = 4'd2;

endpackage

//--- verilog/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// ------------------------------
// Core sizing
// ------------------------------

// Data path width in bits
`define CORE_XLEN 32

// Architectural integer registers, x0 included
`define CORE_NR_REGS 32

// Scoreboard FIFO entries, must stay a power of two
`define CORE_SB_DEPTH 4

`endif
